// ==== src/exec_pkg.sv ====
// Integer execution definitions
package exec_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int MUL_STAGES = 5;
	localparam int SHAMT_W    = 5;
	localparam int IMM_W      = 12;
	localparam int OPC_W      = 7;
	localparam int F3_W       = 3;
	localparam int F7_W       = 7;

	localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
	localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;

	// MUL shares funct3 000 with ADD
	localparam logic [F3_W-1:0] F3_ADD = 3'b000;
	localparam logic [F3_W-1:0] F3_SLL = 3'b001;
	localparam logic [F3_W-1:0] F3_SLT = 3'b010;
	localparam logic [F3_W-1:0] F3_XOR = 3'b100;
	localparam logic [F3_W-1:0] F3_SRL = 3'b101;
	localparam logic [F3_W-1:0] F3_OR  = 3'b110;
	localparam logic [F3_W-1:0] F3_AND = 3'b111;

	localparam logic [F7_W-1:0] F7_BASE   = 7'b0000000;
	localparam logic [F7_W-1:0] F7_ALT    = 7'b0100000;
	localparam logic [F7_W-1:0] F7_MULDIV = 7'b0000001;

	// Same instruction word seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [F7_W-1:0]       funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [F3_W-1:0]       funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [OPC_W-1:0]      opcode;
		} r;
		struct packed {
			logic [IMM_W-1:0]      imm;
			logic [REG_ADDR_W-1:0] rs1;
			logic [F3_W-1:0]       funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [OPC_W-1:0]      opcode;
		} i;
	} instr_u;

endpackage

// ==== src/int_registers.sv ====
// Integer register file
`timescale 1ns/1ps

module int_registers import exec_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] read_addr_a_i,
	input  logic [REG_ADDR_W-1:0] read_addr_b_i,
	input  logic                  write_enable_i,
	input  logic [REG_ADDR_W-1:0] write_addr_i,
	input  logic [XLEN-1:0]       write_data_i,
	output logic [XLEN-1:0]       read_data_a_o,
	output logic [XLEN-1:0]       read_data_b_o
);

	logic [XLEN-1:0] regs_q [NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs_q[r] <= '0;
			end
		end else if (write_enable_i && write_addr_i != '0) begin
			regs_q[write_addr_i] <= write_data_i;
		end
	end

	// Old value on a same-cycle write, write-back forwarding covers it
	assign read_data_a_o = regs_q[read_addr_a_i];
	assign read_data_b_o = regs_q[read_addr_b_i];

	x0_stays_zero: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(write_enable_i && write_addr_i == '0) |=> (regs_q[0] == '0)
	) else $error("x0 changed after a write to it");

endmodule

// ==== src/bypass_ctrl.sv ====
// Operand forwarding and decode stall
`timescale 1ns/1ps

module bypass_ctrl import exec_pkg::*; (
	input  logic                                  dec_valid_i,
	input  logic                                  dec_is_mul_i,
	input  logic [REG_ADDR_W-1:0]                 dec_rs1_i,
	input  logic [REG_ADDR_W-1:0]                 dec_rs2_i,
	input  logic                                  dec_uses_rs2_i,
	input  logic                                  exe_valid_i,
	input  logic [REG_ADDR_W-1:0]                 exe_addr_i,
	input  logic [XLEN-1:0]                       exe_data_i,
	input  logic [MUL_STAGES-1:0]                 mult_valid_i,
	input  logic [MUL_STAGES-1:0][REG_ADDR_W-1:0] mult_addrs_i,
	input  logic                                  wb_valid_i,
	input  logic [REG_ADDR_W-1:0]                 wb_addr_i,
	input  logic [XLEN-1:0]                       wb_data_i,
	output logic                                  bypass_a_en_o,
	output logic                                  bypass_b_en_o,
	output logic [XLEN-1:0]                       bypass_data_a_o,
	output logic [XLEN-1:0]                       bypass_data_b_o,
	output logic                                  stall_o
);

	logic a_exe;
	logic a_wb;
	logic b_exe;
	logic b_wb;
	logic src_stall;
	logic order_stall;

	// x0 is never a real dependency
	function automatic logic hit(input logic v, input logic [REG_ADDR_W-1:0] src,
			input logic [REG_ADDR_W-1:0] dst);
		return v && src != '0 && src == dst;
	endfunction

	function automatic logic mult_hit(input logic [REG_ADDR_W-1:0] src,
			input logic [MUL_STAGES-1:0] valid,
			input logic [MUL_STAGES-1:0][REG_ADDR_W-1:0] addrs);
		logic found;
		found = 1'b0;
		for (int s = 0; s < MUL_STAGES; s++) begin
			found |= hit(valid[s], src, addrs[s]);
		end
		return found;
	endfunction

	// Execute result wins over write-back
	assign a_exe = hit(exe_valid_i, dec_rs1_i, exe_addr_i);
	assign a_wb  = hit(wb_valid_i, dec_rs1_i, wb_addr_i);
	assign b_exe = hit(exe_valid_i, dec_rs2_i, exe_addr_i);
	assign b_wb  = hit(wb_valid_i, dec_rs2_i, wb_addr_i);

	assign bypass_a_en_o   = a_exe | a_wb;
	assign bypass_b_en_o   = b_exe | b_wb;
	assign bypass_data_a_o = a_exe ? exe_data_i : wb_data_i;
	assign bypass_data_b_o = b_exe ? exe_data_i : wb_data_i;

	// Products are not forwarded, so wait for them to reach write-back
	assign src_stall = mult_hit(dec_rs1_i, mult_valid_i, mult_addrs_i)
		| (dec_uses_rs2_i & mult_hit(dec_rs2_i, mult_valid_i, mult_addrs_i));
	// Keeps ALU results behind older products
	assign order_stall = ~dec_is_mul_i & (|mult_valid_i);

	assign stall_o = dec_valid_i & (src_stall | order_stall);

	always_comb begin
		stall_needs_mult: assert #0 (!stall_o || (|mult_valid_i))
			else $error("decode stall with every multiply stage empty");
	end

endmodule

// ==== src/decode_stage.sv ====
// Decode stage and execute latch
`timescale 1ns/1ps

module decode_stage import exec_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  instr_valid_i,
	input  instr_u                instr_i,
	input  logic                  stall_i,
	input  logic                  bypass_a_en_i,
	input  logic                  bypass_b_en_i,
	input  logic [XLEN-1:0]       bypass_data_a_i,
	input  logic [XLEN-1:0]       bypass_data_b_i,
	input  logic [XLEN-1:0]       reg_data_a_i,
	input  logic [XLEN-1:0]       reg_data_b_i,
	output logic                  instr_ready_o,
	output logic                  dec_valid_o,
	output logic                  dec_is_mul_o,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	output logic                  uses_rs2_o,
	output logic                  exe_valid_o,
	output logic                  exe_is_mul_o,
	output logic [REG_ADDR_W-1:0] exe_addr_o,
	output logic [XLEN-1:0]       exe_op_a_o,
	output logic [XLEN-1:0]       exe_op_b_o,
	output logic [F3_W-1:0]       exe_funct3_o,
	output logic                  exe_alt_o
);

	instr_u          dec_q;
	logic            dec_valid_q;
	logic            is_op;
	logic            is_op_imm;
	logic            r_ok;
	logic            i_ok;
	logic            writes_rd;
	logic            mul_hold;
	logic            hold;
	logic [XLEN-1:0] imm_ext;

	assign is_op     = dec_q.r.opcode == OPC_OP;
	assign is_op_imm = dec_q.i.opcode == OPC_OP_IMM;

	always_comb begin
		r_ok = 1'b0;
		i_ok = 1'b0;
		case (dec_q.r.funct3)
			F3_ADD: begin
				r_ok = dec_q.r.funct7 inside {F7_BASE, F7_ALT, F7_MULDIV};
				i_ok = 1'b1;
			end
			F3_SLT, F3_XOR, F3_OR, F3_AND: begin
				r_ok = dec_q.r.funct7 == F7_BASE;
				i_ok = 1'b1;
			end
			F3_SLL, F3_SRL: r_ok = dec_q.r.funct7 == F7_BASE;
			default: ;
		endcase
	end

	assign writes_rd = dec_valid_q & ((is_op & r_ok) | (is_op_imm & i_ok))
		& (dec_q.r.rd != '0);

	assign dec_valid_o  = dec_valid_q;
	assign dec_is_mul_o = is_op & (dec_q.r.funct7 == F7_MULDIV);
	assign rs1_o        = dec_q.r.rs1;
	assign rs2_o        = dec_q.r.rs2;
	assign uses_rs2_o   = is_op;

	// A MUL still in execute has no product yet and is not in the multiply stages
	assign mul_hold = exe_valid_o & exe_is_mul_o & (~dec_is_mul_o
		| (rs1_o == exe_addr_o) | (uses_rs2_o & (rs2_o == exe_addr_o)));
	assign hold          = dec_valid_q & (stall_i | mul_hold);
	assign instr_ready_o = ~hold;

	assign imm_ext = {{(XLEN-IMM_W){dec_q.i.imm[IMM_W-1]}}, dec_q.i.imm};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			dec_valid_q <= 1'b0;
			exe_valid_o <= 1'b0;
		end else begin
			if (instr_ready_o) begin
				dec_valid_q <= instr_valid_i;
			end
			// Bubble into execute while held
			exe_valid_o <= writes_rd & ~hold;
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_ready_o && instr_valid_i) begin
			dec_q <= instr_i;
		end
		exe_is_mul_o <= dec_is_mul_o;
		exe_addr_o   <= dec_q.r.rd;
		exe_op_a_o   <= bypass_a_en_i ? bypass_data_a_i : reg_data_a_i;
		exe_op_b_o   <= is_op_imm ? imm_ext : (bypass_b_en_i ? bypass_data_b_i : reg_data_b_i);
		exe_funct3_o <= dec_q.i.funct3;
		exe_alt_o    <= is_op & (dec_q.r.funct7 == F7_ALT);
	end

endmodule

// ==== src/int_alu.sv ====
// Integer ALU
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
	input  logic [XLEN-1:0] exe_op_a_i,
	input  logic [XLEN-1:0] exe_op_b_i,
	input  logic [F3_W-1:0] exe_funct3_i,
	input  logic            exe_alt_i,
	output logic [XLEN-1:0] result_o
);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = exe_op_b_i[SHAMT_W-1:0];

	always_comb begin
		case (exe_funct3_i)
			F3_ADD: begin
				// alt only comes with R-type SUB
				if (exe_alt_i) begin
					result_o = exe_op_a_i - exe_op_b_i;
				end else begin
					result_o = exe_op_a_i + exe_op_b_i;
				end
			end
			F3_SLL: begin
				result_o = exe_op_a_i << shamt;
			end
			F3_SLT: begin
				result_o = {{(XLEN-1){1'b0}}, $signed(exe_op_a_i) < $signed(exe_op_b_i)};
			end
			F3_XOR: begin
				result_o = exe_op_a_i ^ exe_op_b_i;
			end
			F3_SRL: begin
				result_o = exe_op_a_i >> shamt;
			end
			F3_OR: begin
				result_o = exe_op_a_i | exe_op_b_i;
			end
			F3_AND: begin
				result_o = exe_op_a_i & exe_op_b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// ==== src/mult_pipe.sv ====
// Multiply delay line
`timescale 1ns/1ps

module mult_pipe import exec_pkg::*; (
	input  logic                                  clk_i,
	input  logic                                  rst_n_i,
	input  logic                                  start_i,
	input  logic [REG_ADDR_W-1:0]                 addr_i,
	input  logic [XLEN-1:0]                       op_a_i,
	input  logic [XLEN-1:0]                       op_b_i,
	output logic [MUL_STAGES-1:0]                 stage_valid_o,
	output logic [MUL_STAGES-1:0][REG_ADDR_W-1:0] stage_addrs_o,
	output logic                                  done_o,
	output logic [REG_ADDR_W-1:0]                 done_addr_o,
	output logic [XLEN-1:0]                       done_data_o
);

	logic [MUL_STAGES-1:0]                 valid_q;
	logic [MUL_STAGES-1:0][REG_ADDR_W-1:0] addr_q;
	logic [MUL_STAGES-1:0][XLEN-1:0]       data_q;
	logic [XLEN-1:0]                       product;

	// Low word only, the rest of the stages just carry it
	assign product = XLEN'(op_a_i * op_b_i);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[MUL_STAGES-2:0], start_i};
		end
	end

	always_ff @(posedge clk_i) begin
		addr_q <= {addr_q[MUL_STAGES-2:0], addr_i};
		data_q <= {data_q[MUL_STAGES-2:0], product};
	end

	// Stage 0 is the first register after execute
	assign stage_valid_o = valid_q;
	assign stage_addrs_o = addr_q;

	assign done_o      = valid_q[MUL_STAGES-1];
	assign done_addr_o = addr_q[MUL_STAGES-1];
	assign done_data_o = data_q[MUL_STAGES-1];

endmodule

// ==== src/write_latch.sv ====
// Write-back latch
`timescale 1ns/1ps

module write_latch import exec_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  alu_valid_i,
	input  logic [REG_ADDR_W-1:0] alu_addr_i,
	input  logic [XLEN-1:0]       alu_data_i,
	input  logic                  mul_valid_i,
	input  logic [REG_ADDR_W-1:0] mul_addr_i,
	input  logic [XLEN-1:0]       mul_data_i,
	output logic                  wb_valid_o,
	output logic [REG_ADDR_W-1:0] wb_addr_o,
	output logic [XLEN-1:0]       wb_data_o
);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= alu_valid_i | mul_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_addr_o <= alu_valid_i ? alu_addr_i : mul_addr_i;
		wb_data_o <= alu_valid_i ? alu_data_i : mul_data_i;
	end

	// Decode stalls are what keep the two paths apart
	no_wb_collision: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_valid_i && mul_valid_i)
	) else $error("ALU and multiply completions in the same cycle");

endmodule

// ==== src/exec_core.sv ====
// Integer execution core
`timescale 1ns/1ps

module exec_core import exec_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  instr_valid_i,
	input  instr_u                instr_i,
	output logic                  instr_ready_o,
	output logic                  wb_valid_o,
	output logic [REG_ADDR_W-1:0] wb_addr_o,
	output logic [XLEN-1:0]       wb_data_o
);

	logic [XLEN-1:0]                       reg_data_a;
	logic [XLEN-1:0]                       reg_data_b;
	logic                                  bypass_a_en;
	logic                                  bypass_b_en;
	logic [XLEN-1:0]                       bypass_data_a;
	logic [XLEN-1:0]                       bypass_data_b;
	logic                                  stall;
	logic                                  dec_valid;
	logic                                  dec_is_mul;
	logic [REG_ADDR_W-1:0]                 dec_rs1;
	logic [REG_ADDR_W-1:0]                 dec_rs2;
	logic                                  dec_uses_rs2;
	logic                                  exe_valid;
	logic                                  exe_is_mul;
	logic [REG_ADDR_W-1:0]                 exe_addr;
	logic [XLEN-1:0]                       exe_op_a;
	logic [XLEN-1:0]                       exe_op_b;
	logic [F3_W-1:0]                       exe_funct3;
	logic                                  exe_alt;
	logic [XLEN-1:0]                       alu_result;
	logic [MUL_STAGES-1:0]                 mult_valid;
	logic [MUL_STAGES-1:0][REG_ADDR_W-1:0] mult_addrs;
	logic                                  mul_done;
	logic [REG_ADDR_W-1:0]                 mul_done_addr;
	logic [XLEN-1:0]                       mul_done_data;

	int_registers i_int_registers (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.read_addr_a_i(dec_rs1), .read_addr_b_i(dec_rs2),
		.write_enable_i(wb_valid_o), .write_addr_i(wb_addr_o), .write_data_i(wb_data_o),
		.read_data_a_o(reg_data_a), .read_data_b_o(reg_data_b)
	);

	// Only an ALU result in execute can be forwarded
	bypass_ctrl i_bypass_ctrl (
		.dec_valid_i(dec_valid), .dec_is_mul_i(dec_is_mul),
		.dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .dec_uses_rs2_i(dec_uses_rs2),
		.exe_valid_i(exe_valid & ~exe_is_mul), .exe_addr_i(exe_addr), .exe_data_i(alu_result),
		.mult_valid_i(mult_valid), .mult_addrs_i(mult_addrs),
		.wb_valid_i(wb_valid_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
		.bypass_a_en_o(bypass_a_en), .bypass_b_en_o(bypass_b_en),
		.bypass_data_a_o(bypass_data_a), .bypass_data_b_o(bypass_data_b),
		.stall_o(stall)
	);

	decode_stage i_decode_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.instr_valid_i(instr_valid_i), .instr_i(instr_i), .stall_i(stall),
		.bypass_a_en_i(bypass_a_en), .bypass_b_en_i(bypass_b_en),
		.bypass_data_a_i(bypass_data_a), .bypass_data_b_i(bypass_data_b),
		.reg_data_a_i(reg_data_a), .reg_data_b_i(reg_data_b),
		.instr_ready_o(instr_ready_o),
		.dec_valid_o(dec_valid), .dec_is_mul_o(dec_is_mul),
		.rs1_o(dec_rs1), .rs2_o(dec_rs2), .uses_rs2_o(dec_uses_rs2),
		.exe_valid_o(exe_valid), .exe_is_mul_o(exe_is_mul), .exe_addr_o(exe_addr),
		.exe_op_a_o(exe_op_a), .exe_op_b_o(exe_op_b),
		.exe_funct3_o(exe_funct3), .exe_alt_o(exe_alt)
	);

	int_alu i_int_alu (
		.exe_op_a_i(exe_op_a), .exe_op_b_i(exe_op_b),
		.exe_funct3_i(exe_funct3), .exe_alt_i(exe_alt),
		.result_o(alu_result)
	);

	mult_pipe i_mult_pipe (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.start_i(exe_valid & exe_is_mul), .addr_i(exe_addr),
		.op_a_i(exe_op_a), .op_b_i(exe_op_b),
		.stage_valid_o(mult_valid), .stage_addrs_o(mult_addrs),
		.done_o(mul_done), .done_addr_o(mul_done_addr), .done_data_o(mul_done_data)
	);

	write_latch i_write_latch (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.alu_valid_i(exe_valid & ~exe_is_mul), .alu_addr_i(exe_addr), .alu_data_i(alu_result),
		.mul_valid_i(mul_done), .mul_addr_i(mul_done_addr), .mul_data_i(mul_done_data),
		.wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
	);

endmodule

// ==== tests/exec_core_tb.sv ====
// Execution core testbench
`timescale 1ns/1ps

module exec_core_tb import exec_pkg::*; ();

	logic                  clk;
	logic                  rst_n;
	logic                  instr_valid;
	instr_u                instr;
	logic                  instr_ready;
	logic                  wb_valid;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [XLEN-1:0]       wb_data;

	string                 cur_test;
	int                    test_errors;
	int                    total_errors;
	int                    tests_passed;
	int                    tests_failed;
	logic                  aborted;
	logic [31:0]           rng_state;

	// Expected write-backs of the running test, oldest first
	logic [REG_ADDR_W-1:0] exp_addr_q [$];
	logic [XLEN-1:0]       exp_data_q [$];

	// Trace contents, each entry tagged with the index of its test
	string                 test_names [$];
	int                    instr_owner [$];
	instr_u                instr_words [$];
	int                    exp_owner [$];
	logic [REG_ADDR_W-1:0] trace_addr [$];
	logic [XLEN-1:0]       trace_data [$];

	exec_core i_exec_core (
		.clk_i(clk), .rst_n_i(rst_n),
		.instr_valid_i(instr_valid), .instr_i(instr), .instr_ready_o(instr_ready),
		.wb_valid_o(wb_valid), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic check_addr(input logic [REG_ADDR_W-1:0] expected,
			input logic [REG_ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch in %s: wb_addr_o expected x%0d actual x%0d",
				cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_data(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch in %s: wb_data_o expected %h actual %h",
				cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string signal, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch in %s: %s expected %b actual %b",
				cur_test, signal, expected, actual);
			test_errors++;
		end
	endtask

	// Write-back monitor, sampled away from the rising edge
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_addr_q.size() == 0) begin
				$display("unexpected write-back of %h to x%0d in test %s",
					wb_data, wb_addr, cur_test);
				test_errors++;
			end else begin
				check_addr(exp_addr_q.pop_front(), wb_addr);
				check_data(exp_data_q.pop_front(), wb_data);
			end
		end
	end

	// Returns 1 ns after the edge that accepted the word
	task automatic send_instr(input instr_u word);
		int   idle;
		int   waited;
		logic ready;
		idle = int'(next_rand() % 4);
		repeat (idle) begin
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b1;
		instr = word;
		waited = 0;
		ready = 1'b0;
		while (!ready && !aborted) begin
			@(negedge clk);
			ready = instr_ready;
			@(posedge clk);
			#1;
			waited++;
			if (!ready && waited >= 200) begin
				$display("timed out waiting for instr_ready_o with word %h in test %s",
					word, cur_test);
				test_errors++;
				aborted = 1'b1;
			end
		end
		instr_valid = 1'b0;
	endtask

	task automatic wait_writebacks();
		int waited;
		int left;
		waited = 0;
		left = exp_addr_q.size();
		while (exp_addr_q.size() != 0 && !aborted) begin
			@(posedge clk);
			#1;
			if (exp_addr_q.size() < left) begin
				left = exp_addr_q.size();
				waited = 0;
			end else begin
				waited++;
			end
			if (waited >= 200) begin
				$display("timed out waiting for the write-back to x%0d in test %s",
					exp_addr_q[0], cur_test);
				test_errors++;
				aborted = 1'b1;
			end
		end
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	task automatic run_test(input int t);
		cur_test = test_names[t];
		for (int k = 0; k < exp_owner.size(); k++) begin
			if (exp_owner[k] == t) begin
				exp_addr_q.push_back(trace_addr[k]);
				exp_data_q.push_back(trace_data[k]);
			end
		end
		for (int k = 0; k < instr_owner.size(); k++) begin
			if (instr_owner[k] == t && !aborted) begin
				send_instr(instr_words[k]);
			end
		end
		wait_writebacks();
		// Longest path through the pipe, so a stray write-back lands in this test
		repeat (MUL_STAGES + 4) @(posedge clk);
		#1;
		finish_test();
	endtask

	initial begin
		int          fd;
		int          code;
		string       tok;
		string       name;
		string       rest;
		logic [31:0] word;
		logic [31:0] wa;
		logic [31:0] wd;
		rng_state = 32'h99f;
		aborted = 1'b0;
		test_errors = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_test = "reset";
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;

		fd = $fopen("tests/exec_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/exec_trace.txt");
			aborted = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1) begin
					break;
				end
				if (tok == "T") begin
					code = $fscanf(fd, "%s", name);
					test_names.push_back(name);
				end else if (tok == "I") begin
					code = $fscanf(fd, "%h", word);
					instr_owner.push_back(test_names.size() - 1);
					instr_words.push_back(word);
				end else if (tok == "W") begin
					code = $fscanf(fd, "%h %h", wa, wd);
					exp_owner.push_back(test_names.size() - 1);
					trace_addr.push_back(wa[REG_ADDR_W-1:0]);
					trace_data.push_back(wd);
				end else if (tok.getc(0) == "#") begin
					code = $fgets(rest, fd);
				end else begin
					$display("unknown record %s in the trace file", tok);
					aborted = 1'b1;
					break;
				end
			end
			$fclose(fd);
		end

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("instr_ready_o", 1'b1, instr_ready);
		check_flag("wb_valid_o", 1'b0, wb_valid);
		@(posedge clk);
		#1;
		finish_test();

		for (int t = 0; t < test_names.size(); t++) begin
			if (!aborted) begin
				run_test(t);
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
		if (!aborted && total_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== tests/exec_trace.txt ====
# T test_name, then I instruction_word_hex per instruction
# an I may be followed by W rd_hex data_hex, its expected write-back in program order
T reset_zero
I 000002B3 W 05 00000000
I 00838333 W 06 00000000
T alu_ops
I 12300093 W 01 00000123
I FFB00113 W 02 FFFFFFFB
I 002081B3 W 03 0000011E
I 40208233 W 04 00000128
I 0020F2B3 W 05 00000123
I 0020E333 W 06 FFFFFFFB
I 0020C3B3 W 07 FFFFFED8
I 00112433 W 08 00000001
I 0020A4B3 W 09 00000000
I FFC12513 W 0A 00000001
I 00400593 W 0B 00000004
I 00B09633 W 0C 00001230
I 00B156B3 W 0D 0FFFFFFF
I 02400713 W 0E 00000024
I 00E097B3 W 0F 00001230
I 0F017813 W 10 000000F0
I 8000E893 W 11 FFFFF923
I FFF0C913 W 12 FFFFFEDC
T fwd_chain
I 00700093 W 01 00000007
I 00108133 W 02 0000000E
I 001101B3 W 03 00000015
I 40218233 W 04 00000007
I 003242B3 W 05 00000012
I 00108093 W 01 00000008
T mul_burst
I 7FF00093 W 01 000007FF
I FFD00113 W 02 FFFFFFFD
I 3E800193 W 03 000003E8
I 02208233 W 04 FFFFE803
I 023082B3 W 05 001F3C18
I 02310333 W 06 FFFFF448
I 023183B3 W 07 000F4240
T mul_deps
I 02420433 W 08 023F7009
I 028404B3 W 09 7975E051
I 00148533 W 0A 7975E850
I 022185B3 W 0B FFFFF448
I 00900613 W 0C 00000009
I 02B606B3 W 0D FFFF9688
T no_writeback
I 00208033
I 00500013
I 02108033
I 00109093
I 123450B7
I 00000733 W 0E 00000000
I 000087B3 W 0F 000007FF

// ==== src.f ====
src/exec_pkg.sv
src/int_registers.sv
src/bypass_ctrl.sv
src/decode_stage.sv
src/int_alu.sv
src/mult_pipe.sv
src/write_latch.sv
src/exec_core.sv
tests/exec_core_tb.sv
